// ==== dcache_store.f ====
design/dcache_geom_pkg.sv
design/dcache_op_pkg.sv
design/dcache_tag_meta_array.sv
design/dcache_data_array.sv
design/dcache_main_pipe.sv
design/dcache_store_top.sv
tests/dcache_store_tb.sv

// ==== design/dcache_data_array.sv ====
/* line storage for both ways, registered read of a full set, full-line write */

`timescale 1ns/1ps

module dcache_data_array (
  input  logic                                   clk,
  // read port, both ways of one set
  input  logic                                   rd_en_i,
  input  logic [dcache_geom_pkg::index_w-1:0]    rd_index_i,
  output logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::line_w-1:0] rd_line_o,
  // write port, one whole line
  input  logic                                   wr_en_i,
  input  logic [dcache_geom_pkg::index_w-1:0]    wr_index_i,
  input  logic [dcache_geom_pkg::way_w-1:0]      wr_way_i,
  input  logic [dcache_geom_pkg::line_w-1:0]     wr_line_i
);

  import dcache_geom_pkg::*;

  // ==================================================
  // storage
  // ==================================================

  // contents only matter where the meta valid bit is set
  logic [line_w-1:0] line_mem [num_sets][num_ways];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      line_mem[wr_index_i][wr_way_i] <= wr_line_i;
    end
  end

  // ==================================================
  // read
  // ==================================================

  // whole set at once, way select happens in stage 2
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      for (int w = 0; w < num_ways; w++) begin
        rd_line_o[w] <= line_mem[rd_index_i][w];
      end
    end
  end

endmodule

// ==== design/dcache_geom_pkg.sv ====
/* data cache geometry: set, way and line sizes, physical address field widths */

package dcache_geom_pkg;

  // ==================================================
  // basic sizes
  // ==================================================

  // physical address, no translation
  localparam int addr_w         = 32;

  localparam int num_sets       = 16;
  localparam int num_ways       = 2;

  // line size in bytes and in 32-bit words
  localparam int line_bytes     = 16;
  localparam int words_per_line = 4;

  // ==================================================
  // address fields
  // ==================================================

  // byte offset inside a line
  localparam int offset_w       = $clog2(line_bytes);

  // set index sits right above the offset
  localparam int index_w        = $clog2(num_sets);

  // whatever is left is tag
  localparam int tag_w          = addr_w - index_w - offset_w;

  // word select inside the line, bits [3:2]
  localparam int word_off_w     = $clog2(words_per_line);

  // ==================================================
  // storage widths
  // ==================================================

  localparam int way_w          = $clog2(num_ways);
  localparam int line_w         = line_bytes * 8;

endpackage

// ==== design/dcache_main_pipe.sv ====
/* wishbone slave front end and three-stage lookup pipeline with hit/miss,
   plru victim, store merge, array write-back and eviction */

`timescale 1ns/1ps

module dcache_main_pipe (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // wishbone classic slave
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [dcache_geom_pkg::addr_w-1:0]     wb_adr_i,
  input  logic [3:0]                             wb_sel_i,
  input  logic [31:0]                            wb_dat_i,
  output logic [31:0]                            wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   wb_err_o,
  // tag/meta array
  output logic                                   tm_rd_en_o,
  output logic [dcache_geom_pkg::index_w-1:0]    tm_rd_index_o,
  input  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::tag_w-1:0] tm_rd_tag_i,
  input  logic [dcache_geom_pkg::num_ways-1:0][dcache_op_pkg::meta_w-1:0] tm_rd_meta_i,
  input  logic                                   tm_rd_plru_i,
  output logic                                   tm_wr_en_o,
  output logic [dcache_geom_pkg::index_w-1:0]    tm_wr_index_o,
  output logic [dcache_geom_pkg::way_w-1:0]      tm_wr_way_o,
  output logic [dcache_geom_pkg::tag_w-1:0]      tm_wr_tag_o,
  output logic [dcache_op_pkg::meta_w-1:0]       tm_wr_meta_o,
  output logic                                   plru_wr_en_o,
  output logic                                   plru_wr_val_o,
  // data array
  output logic                                   data_rd_en_o,
  output logic [dcache_geom_pkg::index_w-1:0]    data_rd_index_o,
  input  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::line_w-1:0] data_rd_line_i,
  output logic                                   data_wr_en_o,
  output logic [dcache_geom_pkg::index_w-1:0]    data_wr_index_o,
  output logic [dcache_geom_pkg::way_w-1:0]      data_wr_way_o,
  output logic [dcache_geom_pkg::line_w-1:0]     data_wr_line_o,
  // eviction port without back-pressure
  output logic                                   evict_valid_o,
  output logic [dcache_geom_pkg::addr_w-1:0]     evict_addr_o,
  output logic [dcache_geom_pkg::line_w-1:0]     evict_line_o
);

  import dcache_geom_pkg::*;
  import dcache_op_pkg::*;

  pipe_state_e state_q, state_d;
  dcache_op_e  s0_op, s1_op, s2_op;
  logic        accept, s1_valid, s2_valid;
  logic [addr_w-1:0] s1_addr, s2_addr;
  logic [3:0]  s1_sel, s2_sel;
  logic [31:0] s1_data, s2_data;
  logic [index_w-1:0] s1_index, s2_index;
  logic [tag_w-1:0]   s1_tag, s2_tag, s2_victim_tag;
  logic [way_w-1:0]   s1_hit_way, s1_victim_way, s1_way, s2_way;
  logic        s1_hit, s2_hit, s2_victim_valid, s2_store, s2_illegal;
  logic [word_off_w-1:0] s2_word;
  logic [words_per_line-1:0][31:0] base_line, merged_line;

  // ==================================================
  // stage 0 accepts, decodes and reads tag/meta
  // ==================================================
  assign accept = (state_q == st_idle) && wb_cyc_i && wb_stb_i;

  always_comb begin
    if (!wb_we_i) begin
      s0_op = op_load;
    end else begin
      case (wb_sel_i)
        4'b0001, 4'b0010, 4'b0100, 4'b1000: s0_op = op_store_b;
        4'b0011, 4'b1100:                   s0_op = op_store_h;
        4'b1111:                            s0_op = op_store_w;
        default:                            s0_op = op_illegal;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (accept) state_d = st_busy;
      // response goes out in the cycle s2_valid is high
      st_busy: if (s2_valid) state_d = st_resp;
      st_resp: if (!wb_stb_i) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  assign tm_rd_en_o    = accept;
  assign tm_rd_index_o = wb_adr_i[offset_w +: index_w];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= st_idle;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      state_q  <= state_d;
      s1_valid <= accept;
      s2_valid <= s1_valid;
    end
  end

  // ==================================================
  // stage 1 matches tags, picks the victim, reads data
  // ==================================================
  assign s1_index = s1_addr[offset_w +: index_w];
  assign s1_tag   = s1_addr[addr_w-1 -: tag_w];

  always_comb begin
    s1_hit     = 1'b0;
    s1_hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (tm_rd_meta_i[w][meta_valid_bit] && (tm_rd_tag_i[w] == s1_tag)) begin
        s1_hit     = 1'b1;
        s1_hit_way = way_w'(w);
      end
    end
  end

  assign s1_victim_way   = tm_rd_plru_i;
  assign s1_way          = s1_hit ? s1_hit_way : s1_victim_way;
  assign data_rd_en_o    = s1_valid;
  assign data_rd_index_o = s1_index;

  // payload registers qualified by s1_valid and s2_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op   <= s0_op;
      s1_addr <= wb_adr_i;
      s1_sel  <= wb_sel_i;
      s1_data <= wb_dat_i;
    end
    if (s1_valid) begin
      s2_op           <= s1_op;
      s2_addr         <= s1_addr;
      s2_sel          <= s1_sel;
      s2_data         <= s1_data;
      s2_hit          <= s1_hit;
      s2_way          <= s1_way;
      s2_victim_tag   <= tm_rd_tag_i[s1_victim_way];
      s2_victim_valid <= tm_rd_meta_i[s1_victim_way][meta_valid_bit];
    end
  end

  // ==================================================
  // stage 2 merges, writes back and responds
  // ==================================================
  assign s2_index   = s2_addr[offset_w +: index_w];
  assign s2_tag     = s2_addr[addr_w-1 -: tag_w];
  assign s2_word    = s2_addr[2 +: word_off_w];
  assign s2_store   = s2_op inside {op_store_b, op_store_h, op_store_w};
  assign s2_illegal = (s2_op == op_illegal);

  always_comb begin
    // a store miss starts from a zero-filled line
    base_line   = s2_hit ? data_rd_line_i[s2_way] : '0;
    merged_line = base_line;
    if (s2_store) begin
      // byte lanes follow sel as on wishbone
      for (int b = 0; b < 4; b++) begin
        if (s2_sel[b]) begin
          merged_line[s2_word][8*b +: 8] = s2_data[8*b +: 8];
        end
      end
    end
  end

  assign wb_dat_o = (s2_valid && s2_op == op_load && s2_hit) ? base_line[s2_word] : '0;
  assign wb_ack_o = s2_valid && !s2_illegal;
  assign wb_err_o = s2_valid && s2_illegal;

  assign tm_wr_en_o    = s2_valid && s2_store;
  assign tm_wr_index_o = s2_index;
  assign tm_wr_way_o   = s2_way;
  assign tm_wr_tag_o   = s2_tag;

  always_comb begin
    tm_wr_meta_o                 = '0;
    tm_wr_meta_o[meta_valid_bit] = 1'b1;
    tm_wr_meta_o[meta_dirty_bit] = 1'b1;
  end

  // load miss leaves plru alone
  assign plru_wr_en_o  = s2_valid && !s2_illegal && (s2_store || s2_hit);
  assign plru_wr_val_o = ~s2_way;

  assign data_wr_en_o    = s2_valid && s2_store;
  assign data_wr_index_o = s2_index;
  assign data_wr_way_o   = s2_way;
  assign data_wr_line_o  = merged_line;

  // on a miss s2_way is the victim, so its old line is still on the read port
  assign evict_valid_o = s2_valid && s2_store && !s2_hit && s2_victim_valid;
  assign evict_addr_o  = {s2_victim_tag, s2_index, {offset_w{1'b0}}};
  assign evict_line_o  = data_rd_line_i[s2_way];

  // one response pulse per accepted request
  a_resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o))
    else $error("ack or err held for more than one cycle");

  // a valid victim that missed never carries the incoming tag
  a_evict_other_tag: assert property (@(posedge clk) disable iff (!rst_n)
    evict_valid_o |-> (s2_victim_tag != s2_tag))
    else $error("eviction of a line whose tag matches the missing store");

endmodule

// ==== design/dcache_op_pkg.sv ====
/* access opcodes, front-end FSM states and per-way meta bit layout */

package dcache_op_pkg;

  // decoded from wb we/sel in stage 0
  typedef enum logic [2:0] {
    op_load    = 3'd0,
    op_store_b = 3'd1,
    op_store_h = 3'd2,
    op_store_w = 3'd3,
    op_illegal = 3'd7
  } dcache_op_e;

  // wishbone front end, one access in flight
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_busy = 2'd1,
    st_resp = 2'd2
  } pipe_state_e;

  // ==================================================
  // meta field, stored per way
  // ==================================================

  localparam int meta_w         = 2;
  localparam int meta_valid_bit = 0;

  // set on every store, kept alongside valid
  localparam int meta_dirty_bit = 1;

endpackage

// ==== design/dcache_store_top.sv ====
/* data cache store/load path: main pipeline with tag/meta and data arrays */

`timescale 1ns/1ps

module dcache_store_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [dcache_geom_pkg::addr_w-1:0]     wb_adr_i,
  input  logic [3:0]                             wb_sel_i,
  input  logic [31:0]                            wb_dat_i,
  output logic [31:0]                            wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   wb_err_o,
  output logic                                   evict_valid_o,
  output logic [dcache_geom_pkg::addr_w-1:0]     evict_addr_o,
  output logic [dcache_geom_pkg::line_w-1:0]     evict_line_o
);

  import dcache_geom_pkg::*;
  import dcache_op_pkg::*;

  // tag/meta array
  logic                              tm_rd_en, tm_rd_plru, tm_wr_en;
  logic [index_w-1:0]                tm_rd_index, tm_wr_index;
  logic [num_ways-1:0][tag_w-1:0]    tm_rd_tag;
  logic [num_ways-1:0][meta_w-1:0]   tm_rd_meta;
  logic [way_w-1:0]                  tm_wr_way;
  logic [tag_w-1:0]                  tm_wr_tag;
  logic [meta_w-1:0]                 tm_wr_meta;
  logic                              plru_wr_en, plru_wr_val;

  // data array
  logic                              data_rd_en, data_wr_en;
  logic [index_w-1:0]                data_rd_index, data_wr_index;
  logic [num_ways-1:0][line_w-1:0]   data_rd_line;
  logic [way_w-1:0]                  data_wr_way;
  logic [line_w-1:0]                 data_wr_line;

  dcache_main_pipe dcache_main_pipe_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .tm_rd_en_o      (tm_rd_en),
    .tm_rd_index_o   (tm_rd_index),
    .tm_rd_tag_i     (tm_rd_tag),
    .tm_rd_meta_i    (tm_rd_meta),
    .tm_rd_plru_i    (tm_rd_plru),
    .tm_wr_en_o      (tm_wr_en),
    .tm_wr_index_o   (tm_wr_index),
    .tm_wr_way_o     (tm_wr_way),
    .tm_wr_tag_o     (tm_wr_tag),
    .tm_wr_meta_o    (tm_wr_meta),
    .plru_wr_en_o    (plru_wr_en),
    .plru_wr_val_o   (plru_wr_val),
    .data_rd_en_o    (data_rd_en),
    .data_rd_index_o (data_rd_index),
    .data_rd_line_i  (data_rd_line),
    .data_wr_en_o    (data_wr_en),
    .data_wr_index_o (data_wr_index),
    .data_wr_way_o   (data_wr_way),
    .data_wr_line_o  (data_wr_line),
    .evict_valid_o   (evict_valid_o),
    .evict_addr_o    (evict_addr_o),
    .evict_line_o    (evict_line_o)
  );

  dcache_tag_meta_array tag_meta_array_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_en_i       (tm_rd_en),
    .rd_index_i    (tm_rd_index),
    .rd_tag_o      (tm_rd_tag),
    .rd_meta_o     (tm_rd_meta),
    .rd_plru_o     (tm_rd_plru),
    .wr_en_i       (tm_wr_en),
    .wr_index_i    (tm_wr_index),
    .wr_way_i      (tm_wr_way),
    .wr_tag_i      (tm_wr_tag),
    .wr_meta_i     (tm_wr_meta),
    .plru_wr_en_i  (plru_wr_en),
    .plru_wr_val_i (plru_wr_val)
  );

  dcache_data_array data_array_inst (
    .clk        (clk),
    .rd_en_i    (data_rd_en),
    .rd_index_i (data_rd_index),
    .rd_line_o  (data_rd_line),
    .wr_en_i    (data_wr_en),
    .wr_index_i (data_wr_index),
    .wr_way_i   (data_wr_way),
    .wr_line_i  (data_wr_line)
  );

endmodule

// ==== design/dcache_tag_meta_array.sv ====
/* tag, valid/dirty meta and per-set plru storage with registered read of a whole set */

`timescale 1ns/1ps

module dcache_tag_meta_array (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // read port, result one cycle later
  input  logic                                   rd_en_i,
  input  logic [dcache_geom_pkg::index_w-1:0]    rd_index_i,
  output logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::tag_w-1:0] rd_tag_o,
  output logic [dcache_geom_pkg::num_ways-1:0][dcache_op_pkg::meta_w-1:0] rd_meta_o,
  output logic                                   rd_plru_o,
  // write port, one way of one set
  input  logic                                   wr_en_i,
  input  logic [dcache_geom_pkg::index_w-1:0]    wr_index_i,
  input  logic [dcache_geom_pkg::way_w-1:0]      wr_way_i,
  input  logic [dcache_geom_pkg::tag_w-1:0]      wr_tag_i,
  input  logic [dcache_op_pkg::meta_w-1:0]       wr_meta_i,
  input  logic                                   plru_wr_en_i,
  input  logic                                   plru_wr_val_i
);

  import dcache_geom_pkg::*;
  import dcache_op_pkg::*;

  logic [num_ways-1:0][tag_w-1:0]  tag_mem [num_sets];
  logic [num_sets-1:0][num_ways-1:0][meta_w-1:0] meta_q;

  // one bit per set, names the way to replace next
  logic [num_sets-1:0]             plru_q;

  // tags carry no reset, valid bits qualify them
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i][wr_way_i] <= wr_tag_i;
    end
    if (rd_en_i) begin
      rd_tag_o <= tag_mem[rd_index_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q    <= '0;
      plru_q    <= '0;
      rd_meta_o <= '0;
      rd_plru_o <= 1'b0;
    end else begin
      if (wr_en_i) begin
        meta_q[wr_index_i][wr_way_i] <= wr_meta_i;
      end
      if (plru_wr_en_i) begin
        plru_q[wr_index_i] <= plru_wr_val_i;
      end
      if (rd_en_i) begin
        rd_meta_o <= meta_q[rd_index_i];
        rd_plru_o <= plru_q[rd_index_i];
      end
    end
  end

  a_wr_index_known: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en_i |-> !$isunknown(wr_index_i))
    else $error("tag/meta write with unknown index");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module dcache_store_tb \
  -f dcache_store.f \
  --Mdir obj_dir -o dcache_store_sim

./obj_dir/dcache_store_sim 2>&1 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tests/dcache_golden.txt ====
# name we addr sel wdata exp_rdata exp_err exp_evict evict_addr evict_line (all hex)
# evict_line is the whole 128-bit line with word 3 leftmost, only compared when exp_evict is 1
ld_cold 0 00001040 f 00000000 00000000 0 0 00000000 0
ld_cold_again 0 00001040 f 00000000 00000000 0 0 00000000 0
st_cold_word 1 00001040 f cafef00d 00000000 0 0 00000000 0
ld_cold_word 0 00001040 f 00000000 cafef00d 0 0 00000000 0
st_word 1 00002010 f deadbeef 00000000 0 0 00000000 0
st_byte 1 00002014 2 0000ab00 00000000 0 0 00000000 0
st_half 1 0000201c c 12340000 00000000 0 0 00000000 0
ld_w0 0 00002010 f 00000000 deadbeef 0 0 00000000 0
ld_w1 0 00002014 f 00000000 0000ab00 0 0 00000000 0
ld_w2 0 00002018 f 00000000 00000000 0 0 00000000 0
ld_w3 0 0000201c f 00000000 12340000 0 0 00000000 0
cf_st_a 1 00003020 f 11111111 00000000 0 0 00000000 0
cf_st_b 1 00004024 f 22222222 00000000 0 0 00000000 0
cf_st_b_byte 1 0000402c 8 33000000 00000000 0 0 00000000 0
cf_ld_a 0 00003020 f 00000000 11111111 0 0 00000000 0
cf_st_c 1 00005028 f 44444444 00000000 0 1 00004020 33000000000000002222222200000000
cf_ld_b 0 00004024 f 00000000 00000000 0 0 00000000 0
cf_ld_a2 0 00003020 f 00000000 11111111 0 0 00000000 0
cf_ld_c 0 00005028 f 00000000 44444444 0 0 00000000 0
il_sel5 1 00002018 5 ffffffff 00000000 1 0 00000000 0
il_sel6 1 00002018 6 ffffffff 00000000 1 0 00000000 0
il_ld_w2 0 00002018 f 00000000 00000000 0 0 00000000 0
il_ld_w1 0 00002014 f 00000000 0000ab00 0 0 00000000 0

// ==== tests/dcache_store_tb.sv ====
/* data cache store/load path testbench with clock, reset, wishbone master,
   golden-file stimulus and response checks */

`timescale 1ns/1ps

module dcache_store_tb;

  localparam int    resp_timeout = 50;
  localparam int    resp_latency = 2;
  localparam string golden_path  = "tests/dcache_golden.txt";

  logic         clk;
  logic         rst_n;
  logic         wb_cyc, wb_stb, wb_we;
  logic [31:0]  wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0]   wb_sel;
  logic         wb_ack, wb_err;
  logic         evict_valid;
  logic [31:0]  evict_addr;
  logic [127:0] evict_line;

  int access_cnt, mismatch_cnt, timeout_cnt, file_err_cnt;

  dcache_store_top dcache_store_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_sel_i      (wb_sel),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack),
    .wb_err_o      (wb_err),
    .evict_valid_o (evict_valid),
    .evict_addr_o  (evict_addr),
    .evict_line_o  (evict_line)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic report_mismatch(input logic [8*24-1:0] name, input string field,
                                 input logic [127:0] exp_v, input logic [127:0] act_v);
    $display("mismatch %0s %0s: expected %0h actual %0h", name, field, exp_v, act_v);
    mismatch_cnt++;
  endtask

  // ==================================================
  // one wishbone classic cycle plus response checks
  // ==================================================
  task automatic run_access(input logic [8*24-1:0] name, input logic we_v,
                            input logic [31:0] adr_v, input logic [3:0] sel_v,
                            input logic [31:0] wdata_v, input logic [31:0] exp_rdata,
                            input logic exp_err, input logic exp_evict,
                            input logic [31:0] exp_ev_addr, input logic [127:0] exp_ev_line);
    int cycles;
    cycles = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we_v;
    wb_adr   <= adr_v;
    wb_sel   <= sel_v;
    wb_dat_w <= wdata_v;
    // front end is idle, so this edge accepts
    @(posedge clk);
    do begin
      @(negedge clk);
      cycles++;
    end while (!(wb_ack || wb_err) && cycles < resp_timeout);

    if (!(wb_ack || wb_err)) begin
      $display("error: %0s got neither ack nor err within %0d cycles", name, resp_timeout);
      timeout_cnt++;
    end else begin
      assert (cycles == resp_latency)
        else report_mismatch(name, "latency", 128'(resp_latency), 128'(cycles));
      assert (wb_err == exp_err)
        else report_mismatch(name, "err", 128'(exp_err), 128'(wb_err));
      assert (wb_ack == !exp_err)
        else report_mismatch(name, "ack", 128'(!exp_err), 128'(wb_ack));
      assert (wb_dat_r == exp_rdata)
        else report_mismatch(name, "rdata", 128'(exp_rdata), 128'(wb_dat_r));
      assert (evict_valid == exp_evict)
        else report_mismatch(name, "evict_valid", 128'(exp_evict), 128'(evict_valid));
      if (exp_evict) begin
        assert (evict_addr == exp_ev_addr)
          else report_mismatch(name, "evict_addr", 128'(exp_ev_addr), 128'(evict_addr));
        assert (evict_line == exp_ev_line)
          else report_mismatch(name, "evict_line", exp_ev_line, evict_line);
      end
    end

    // drop stb so the slave returns to idle before the next access
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int               fd;
    int               code;
    logic [8*24-1:0]  name;
    logic [8*200-1:0] rest;
    logic             we_v, exp_err, exp_evict;
    logic [31:0]      adr_v, wdata_v, exp_rdata, exp_ev_addr;
    logic [3:0]       sel_v;
    logic [127:0]     exp_ev_line;

    clk          = 1'b0;
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_sel       = '0;
    wb_dat_w     = '0;
    access_cnt   = 0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    file_err_cnt = 0;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("error: cannot open golden file %0s", golden_path);
      file_err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) break;
        // comment lines start with a lone #
        if (name[7:0] == "#" && name[8*24-1:8] == '0) begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", we_v, adr_v, sel_v, wdata_v,
                         exp_rdata, exp_err, exp_evict, exp_ev_addr, exp_ev_line);
          if (code != 9) begin
            $display("error: golden line for %0s has missing fields", name);
            file_err_cnt++;
          end else begin
            run_access(name, we_v, adr_v, sel_v, wdata_v, exp_rdata,
                       exp_err, exp_evict, exp_ev_addr, exp_ev_line);
            access_cnt++;
          end
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    $display("summary: %0d accesses, %0d mismatches, %0d timeouts, %0d file errors",
             access_cnt, mismatch_cnt, timeout_cnt, file_err_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && file_err_cnt == 0 && access_cnt > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
